// ==== vlog.f ====
source/ddr_drv_pkg.sv
source/ddr_test_sequencer.sv
source/ddr_addr_gen.sv
source/ddr_pattern_gen.sv
source/ddr_read_checker.sv
source/ddr_example_driver.sv
dv/ddr_driver_asserts.sv
dv/tb_ddr_example_driver.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then decide pass or fail from the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ddr_example_driver \
  -f vlog.f -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "simulation reported errors"; exit 1; } \
  || { echo "simulation finished clean"; exit 0; }

// ==== dv/tb_ddr_example_driver.sv ====
// testbench: clock, reset, memory model, reference LFSR and address, check tasks, directed tests
module tb_ddr_example_driver;
  timeunit 1ns;
  timeprecision 100ps;

  logic clk, reset_n, local_ready, local_rdata_valid;
  logic write_req, read_req, burstbegin, pnf_persist, test_complete;
  ddr_drv_pkg::data_t local_rdata, wdata, ref_word;
  ddr_drv_pkg::size_t size;
  ddr_drv_pkg::mem_addr_t addr, wr_ref, rd_ref, burst_addr;
  ddr_drv_pkg::be_t be, pnf_per_byte;
  ddr_drv_pkg::status_t test_status;
  ddr_drv_pkg::data_t mem [logic [25:0]];
  ddr_drv_pkg::data_t rq_data[$];
  logic [25:0] rq_key[$];
  longint rq_time[$];
  logic [25:0] key_out, corrupt_key;
  longint cycle, last_t;
  int error_count, wbeats, rbeats, rd_bursts;
  bit clean_mode, persist_seen, corrupt_en, corrupt_sent;

  ddr_example_driver u_ddr_example_driver (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------
  // reference models
  // ----------------------------------------
  function automatic ddr_drv_pkg::data_t lfsr_advance(input ddr_drv_pkg::data_t w);
    ddr_drv_pkg::lane_t b;
    for (int i = 0; i < 4; i++)
    begin
      b = w[8*i +: 8];
      w[8*i +: 8] = {b[6:0], b[7] ^ b[5] ^ b[4] ^ b[3]};
    end
    return w;
  endfunction

  function automatic ddr_drv_pkg::mem_addr_t addr_advance(input ddr_drv_pkg::mem_addr_t a);
    if (a.col < 9'd16)
      a.col = a.col + 9'd4;
    else
    begin
      a.col = '0;
      a.row = (a.row == 13'd3) ? 13'd0 : a.row + 13'd1;
      if (a.row == 13'd0)
        a.bank = a.bank + 2'd1;
    end
    return a;
  endfunction

  task automatic check_data(input string name, input ddr_drv_pkg::data_t got, exp);
    if (got !== exp)
    begin
      error_count++;
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input ddr_drv_pkg::mem_addr_t got, exp);
    if (got !== exp)
    begin
      error_count++;
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_be(input string name, input ddr_drv_pkg::be_t got, exp);
    if (got !== exp)
    begin
      error_count++;
      $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_size(input string name, input ddr_drv_pkg::size_t got, exp);
    if (got !== exp)
    begin
      error_count++;
      $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_status(input string name, input ddr_drv_pkg::status_t got, exp);
    if (got !== exp)
    begin
      error_count++;
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp)
    begin
      error_count++;
      $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // one accepted write beat: reference checks, then byte-enabled store
  task automatic record_write();
    int n;
    logic [25:0] key;
    ddr_drv_pkg::data_t word, mask;
    n = wbeats;
    if (n % 160 == 0)
      wr_ref = '0;
    check_bit("burstbegin", burstbegin, (n % 2) == 0);
    check_size("size", size, 3'd2);
    if (n % 2 == 0)
    begin
      check_addr("addr", addr, wr_ref);
      burst_addr = addr;
      wr_ref = addr_advance(wr_ref);
    end
    if (n < 160)
    begin
      check_status("test_status", test_status, 8'h01);
      check_be("be", be, 4'hf);
      check_data("wdata", wdata, ref_word);
      ref_word = lfsr_advance(ref_word);
    end
    else if (n < 320)
    begin
      check_status("test_status", test_status, 8'h04);
      check_be("be", be, 4'hf);
      check_data("wdata", wdata, '0);
    end
    else
    begin
      check_be("be", be, 4'b0001 << ((n - 320) % 4));
      mask = 32'hff << (8 * ((n - 320) % 4));
      check_data("wdata", wdata & mask, ref_word & mask);
      ref_word = lfsr_advance(ref_word);
    end
    key = {burst_addr, n[0]};
    word = mem.exists(key) ? mem[key] : '0;
    for (int i = 0; i < 4; i++)
      if (be[i])
        word[8*i +: 8] = wdata[8*i +: 8];
    // single lane 2 fault for the detection test
    if (corrupt_en && n == 37)
    begin
      word = word ^ 32'h005a0000;
      corrupt_key = key;
    end
    mem[key] = word;
    wbeats++;
  endtask

  // ----------------------------------------
  // memory model
  // ----------------------------------------
  always @(posedge clk)
  begin
    #2;
    local_ready = ($urandom_range(3, 0) != 0);
    if (reset_n && rq_time.size() > 0 && rq_time[0] <= cycle)
    begin
      local_rdata = rq_data.pop_front();
      key_out = rq_key.pop_front();
      void'(rq_time.pop_front());
      local_rdata_valid = 1'b1;
      if (corrupt_en && key_out == corrupt_key)
        corrupt_sent = 1'b1;
    end
    else
      local_rdata_valid = 1'b0;
    cycle++;
  end

  always @(negedge clk)
  begin
    longint t;
    logic [25:0] k;
    if (!reset_n)
    begin
      wbeats = 0;
      rbeats = 0;
      rd_bursts = 0;
      ref_word = {8'd31, 8'd21, 8'd11, 8'd1};
      last_t = 0;
      rq_data.delete();
      rq_key.delete();
      rq_time.delete();
      mem.delete();
    end
    else
    begin
      if (write_req && local_ready)
        record_write();
      if (read_req && local_ready)
      begin
        if (rd_bursts % 80 == 0)
          rd_ref = '0;
        check_addr("read addr", addr, rd_ref);
        check_size("size", size, 3'd2);
        rd_ref = addr_advance(rd_ref);
        rd_bursts++;
        t = cycle + longint'($urandom_range(6, 2));
        if (t <= last_t)
          t = last_t + 1;
        for (int b = 0; b < 2; b++)
        begin
          k = {addr, b[0]};
          rq_data.push_back(mem.exists(k) ? mem[k] : (32'(k) ^ 32'ha5c3_0f96));
          rq_key.push_back(k);
          rq_time.push_back(t + b);
        end
        last_t = t + 1;
      end
      if (local_rdata_valid)
        rbeats++;
      if (clean_mode)
      begin
        check_be("pnf_per_byte", pnf_per_byte, 4'hf);
        if (persist_seen)
          check_bit("pnf_persist", pnf_persist, 1'b1);
        persist_seen = persist_seen | pnf_persist;
      end
    end
  end

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic apply_reset();
    @(posedge clk);
    #2 reset_n = 1'b0;
    repeat (8) @(posedge clk);
    #2 reset_n = 1'b1;
  endtask

  task automatic wait_complete(input int limit);
    for (int i = 0; i < limit && !test_complete; i++)
      @(negedge clk);
    if (!test_complete)
    begin
      $display("timeout while waiting for test_complete");
      $display("Errors found");
      $finish;
    end
  endtask

  task automatic test_reset_state();
    int i;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_status("test_status", test_status, 8'h00);
    check_bit("write_req", write_req, 1'b0);
    check_bit("read_req", read_req, 1'b0);
    check_bit("test_complete", test_complete, 1'b0);
    repeat (4) @(posedge clk);
    #2 reset_n = 1'b1;
    @(negedge clk);
    check_status("test_status", test_status, 8'h00);
    check_bit("write_req", write_req, 1'b0);
    check_bit("read_req", read_req, 1'b0);
    check_bit("burstbegin", burstbegin, 1'b0);
    check_bit("test_complete", test_complete, 1'b0);
    // first write_req within 3 cycles
    for (i = 0; i < 3 && !write_req; i++)
      @(negedge clk);
    if (!write_req)
    begin
      error_count++;
      $display("write_req did not rise within 3 cycles of reset release");
    end
  endtask

  task automatic test_clean_run();
    clean_mode = 1'b1;
    persist_seen = 1'b0;
    wait_complete(40000);
    check_status("test_status", test_status, 8'h80);
    check_bit("pnf_persist", pnf_persist, 1'b1);
    if (wbeats != 480 || rbeats != 320)
    begin
      error_count++;
      $display("beat counts wrong: %0d writes, %0d reads", wbeats, rbeats);
    end
    repeat (20)
    begin
      @(negedge clk);
      check_bit("test_complete", test_complete, 1'b1);
    end
    clean_mode = 1'b0;
  endtask

  task automatic test_fault_detection();
    int i;
    corrupt_en = 1'b1;
    corrupt_sent = 1'b0;
    apply_reset();
    for (i = 0; i < 20000 && !corrupt_sent; i++)
      @(negedge clk);
    if (!corrupt_sent)
    begin
      $display("timeout while waiting for the corrupted read beat");
      $display("Errors found");
      $finish;
    end
    for (i = 0; i < 4 && pnf_per_byte[2]; i++)
      @(negedge clk);
    check_bit("pnf_per_byte[2]", pnf_per_byte[2], 1'b0);
    for (i = 0; i < 3 && pnf_persist; i++)
      @(negedge clk);
    check_bit("pnf_persist", pnf_persist, 1'b0);
    for (i = 0; i < 40000 && !test_complete; i++)
    begin
      @(negedge clk);
      if (pnf_persist)
      begin
        error_count++;
        $display("pnf_persist recovered after a lane mismatch at t=%0t", $time);
      end
    end
    wait_complete(1);
    corrupt_en = 1'b0;
  endtask

  initial
  begin
    void'($urandom(32'hf217));
    reset_n = 1'b0;
    local_ready = 1'b1;
    local_rdata = '0;
    local_rdata_valid = 1'b0;
    error_count = 0;
    cycle = 0;
    clean_mode = 1'b0;
    corrupt_en = 1'b0;
    corrupt_sent = 1'b0;
    corrupt_key = '1;
    test_reset_state();
    test_clean_run();
    test_fault_detection();
    $display("run finished with %0d errors", error_count);
    if (error_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// ==== dv/ddr_driver_asserts.sv ====
// concurrent assertions on the local port, bound to the driver top level
module ddr_driver_asserts (
  input logic                   clk,
  input logic                   reset_n,
  input logic                   write_req,
  input logic                   read_req,
  input logic                   burstbegin,
  input logic                   local_ready,
  input ddr_drv_pkg::mem_addr_t addr
);
  timeunit 1ns;
  timeprecision 100ps;

  // no request on the first edge out of reset
  a_reset_idle: assert property (@(posedge clk) $rose(reset_n) |-> (!write_req && !read_req))
    else $error("request active right after reset");

  a_req_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
    !(write_req && read_req))
    else $error("write_req and read_req high together");

  a_begin_with_req: assert property (@(posedge clk) disable iff (!reset_n)
    burstbegin |-> (write_req || read_req))
    else $error("burstbegin without a request");

  // address holds while the controller stalls
  a_addr_hold: assert property (@(posedge clk) disable iff (!reset_n)
    ((write_req || read_req) && !local_ready) |=> $stable(addr))
    else $error("address changed during a stalled request");

endmodule

bind ddr_example_driver ddr_driver_asserts u_ddr_driver_asserts (
  .clk         (clk),
  .reset_n     (reset_n),
  .write_req   (write_req),
  .read_req    (read_req),
  .burstbegin  (burstbegin),
  .local_ready (local_ready),
  .addr        (addr)
);

// ==== source/ddr_example_driver.sv ====
// top level: sequencer, address generator, pattern generator and read checker
module ddr_example_driver (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   local_ready,
  input  ddr_drv_pkg::data_t     local_rdata,
  input  logic                   local_rdata_valid,
  output logic                   write_req,
  output logic                   read_req,
  output logic                   burstbegin,
  output ddr_drv_pkg::size_t     size,
  output ddr_drv_pkg::mem_addr_t addr,
  output ddr_drv_pkg::data_t     wdata,
  output ddr_drv_pkg::be_t       be,
  output ddr_drv_pkg::be_t       pnf_per_byte,
  output logic                   pnf_persist,
  output logic                   test_complete,
  output ddr_drv_pkg::status_t   test_status
);

  ddr_drv_pkg::seq_ctrl_t ctrl;
  ddr_drv_pkg::data_t     exp_data;
  logic                   wr_beat;
  logic                   burst_adv;
  logic                   last_addr;

  assign write_req = ctrl.write_req;
  assign read_req  = ctrl.read_req;

  ddr_test_sequencer u_ddr_test_sequencer (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .last_addr         (last_addr),
    .ctrl              (ctrl),
    .wr_beat           (wr_beat),
    .burst_adv         (burst_adv),
    .burstbegin        (burstbegin),
    .size              (size),
    .test_complete     (test_complete),
    .test_status       (test_status)
  );

  ddr_addr_gen u_ddr_addr_gen (
    .clk       (clk),
    .reset_n   (reset_n),
    .ctrl      (ctrl),
    .burst_adv (burst_adv),
    .addr      (addr),
    .last_addr (last_addr)
  );

  ddr_pattern_gen u_ddr_pattern_gen (
    .clk               (clk),
    .reset_n           (reset_n),
    .ctrl              (ctrl),
    .wr_beat           (wr_beat),
    .local_rdata_valid (local_rdata_valid),
    .wdata             (wdata),
    .exp_data          (exp_data),
    .be                (be)
  );

  ddr_read_checker u_ddr_read_checker (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_rdata       (local_rdata),
    .local_rdata_valid (local_rdata_valid),
    .exp_data          (exp_data),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist)
  );

endmodule

// ==== source/ddr_read_checker.sv ====
// read checker: per-lane compare pipeline, per-byte and persistent pass flags
module ddr_read_checker (
  input  logic               clk,
  input  logic               reset_n,
  input  ddr_drv_pkg::data_t local_rdata,
  input  logic               local_rdata_valid,
  input  ddr_drv_pkg::data_t exp_data,
  output ddr_drv_pkg::be_t   pnf_per_byte,
  output logic               pnf_persist
);

  ddr_drv_pkg::lane_t [ddr_drv_pkg::lane_count-1:0] rd_lanes;
  ddr_drv_pkg::lane_t [ddr_drv_pkg::lane_count-1:0] exp_lanes;
  ddr_drv_pkg::be_t                                 compare;
  ddr_drv_pkg::be_t                                 compare_q;
  ddr_drv_pkg::be_t                                 compare_valid;
  logic                                             valid_q;
  logic                                             checked;
  logic                                             checked_d;
  logic                                             pnf_next;

  assign rd_lanes  = local_rdata;
  assign exp_lanes = exp_data;

  // one compare per byte lane
  always_comb
  begin
    for (int i = 0; i < ddr_drv_pkg::lane_count; i++)
      compare[i] = (rd_lanes[i] == exp_lanes[i]);
  end

  // ----------------------------------------
  // compare, capture, output stages
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      compare_q     <= '1;
      valid_q       <= 1'b0;
      compare_valid <= '1;
      checked       <= 1'b0;
      checked_d     <= 1'b0;
      pnf_per_byte  <= '1;
      pnf_next      <= 1'b0;
      pnf_persist   <= 1'b0;
    end
    else
    begin
      compare_q <= compare;
      valid_q   <= local_rdata_valid;
      // keep the last checked result between beats
      if (valid_q)
        compare_valid <= compare_q;
      checked      <= checked | valid_q;
      checked_d    <= checked;
      pnf_per_byte <= compare_valid;
      // first checked beat sets it, any miss clears it for good
      pnf_next    <= checked & (&compare_valid) & (~checked_d | pnf_next);
      pnf_persist <= pnf_next;
    end
  end

endmodule

// ==== source/ddr_pattern_gen.sv ====
// pattern generator: four lane LFSRs, reload word, zero-fill mux and rotating byte enable
module ddr_pattern_gen (
  input  logic                   clk,
  input  logic                   reset_n,
  input  ddr_drv_pkg::seq_ctrl_t ctrl,
  input  logic                   wr_beat,
  input  logic                   local_rdata_valid,
  output ddr_drv_pkg::data_t     wdata,
  output ddr_drv_pkg::data_t     exp_data,
  output ddr_drv_pkg::be_t       be
);

  ddr_drv_pkg::lane_t [ddr_drv_pkg::lane_count-1:0] lanes;
  ddr_drv_pkg::lane_t [ddr_drv_pkg::lane_count-1:0] saved;
  ddr_drv_pkg::lane_t [ddr_drv_pkg::lane_count-1:0] exp_lanes;
  logic                                             advance;
  logic                                             rotate;

  // taps 7, 5, 4, 3
  function automatic ddr_drv_pkg::lane_t lfsr_next(input ddr_drv_pkg::lane_t q);
    logic fb;
    fb = q[7] ^ q[5] ^ q[4] ^ q[3];
    return {q[6:0], fb};
  endfunction

  // zero-fill beats leave the sequence alone
  assign advance = (wr_beat & ~ctrl.zero_fill) | local_rdata_valid;
  assign rotate  = ctrl.dm_mode & ~ctrl.zero_fill & (wr_beat | local_rdata_valid);

  assign wdata    = ctrl.zero_fill ? '0 : lanes;
  assign exp_data = exp_lanes;

  always_comb
  begin
    for (int i = 0; i < ddr_drv_pkg::lane_count; i++)
      exp_lanes[i] = be[i] ? lanes[i] : '0;
  end

  // ----------------------------------------
  // lane LFSRs
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      lanes <= ddr_drv_pkg::lane_seed;
    end
    else if (ctrl.dgen_load)
    begin
      lanes <= saved;
    end
    else if (advance)
    begin
      for (int i = 0; i < ddr_drv_pkg::lane_count; i++)
        lanes[i] <= lfsr_next(lanes[i]);
    end
  end

  // word at the start of the pass
  always_ff @(posedge clk)
  begin
    if (ctrl.capture_seed)
      saved <= lanes;
  end

  // ----------------------------------------
  // byte enables
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      be <= '1;
    else if (ctrl.reset_be)
      be <= 4'b0001;
    else if (rotate)
      be <= {be[2:0], be[3]};
    else if (!ctrl.dm_mode || ctrl.zero_fill)
      be <= '1;
  end

endmodule

// ==== source/ddr_addr_gen.sv ====
// address generator: nested column, row, bank and chip-select wrap counter with last-address flag
module ddr_addr_gen (
  input  logic                   clk,
  input  logic                   reset_n,
  input  ddr_drv_pkg::seq_ctrl_t ctrl,
  input  logic                   burst_adv,
  output ddr_drv_pkg::mem_addr_t addr,
  output logic                   last_addr
);

  // final burst of the range
  assign last_addr = (addr.col == ddr_drv_pkg::max_col) &&
                     (addr.row == ddr_drv_pkg::max_row) &&
                     (addr.bank == ddr_drv_pkg::max_bank) &&
                     (addr.cs == ddr_drv_pkg::max_cs);

  // ----------------------------------------
  // one step per accepted burst start
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      addr <= '0;
    end
    else if (ctrl.reset_address)
    begin
      addr <= '0;
    end
    else if (burst_adv)
    begin
      if (addr.col >= ddr_drv_pkg::max_col)
      begin
        addr.col <= '0;
        // column wrap carries into row
        if (addr.row == ddr_drv_pkg::max_row)
        begin
          addr.row <= '0;
          if (addr.bank == ddr_drv_pkg::max_bank)
          begin
            addr.bank <= '0;
            if (addr.cs == ddr_drv_pkg::max_cs)
              addr.cs <= '0;
            else
              addr.cs <= addr.cs + 1'b1;
          end
          else
          begin
            addr.bank <= addr.bank + 2'd1;
          end
        end
        else
        begin
          addr.row <= addr.row + 13'd1;
        end
      end
      else
      begin
        addr.col <= addr.col + ddr_drv_pkg::col_step;
      end
    end
  end

endmodule

// ==== source/ddr_test_sequencer.sv ====
// test sequencer: pass selection, request generation, burst beat and read drain counting
module ddr_test_sequencer (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   local_ready,
  input  logic                   local_rdata_valid,
  input  logic                   last_addr,
  output ddr_drv_pkg::seq_ctrl_t ctrl,
  output logic                   wr_beat,
  output logic                   burst_adv,
  output logic                   burstbegin,
  output ddr_drv_pkg::size_t     size,
  output logic                   test_complete,
  output ddr_drv_pkg::status_t   test_status
);

  ddr_drv_pkg::seq_state_t state;
  ddr_drv_pkg::beat_cnt_t  beat_cnt;
  logic [7:0]              reads_pending;
  logic                    seq_pending;
  logic                    dm_pending;
  logic                    seq_mode;
  logic                    last_burst;
  logic                    rd_accept;

  assign size      = ddr_drv_pkg::burst_len;
  assign wr_beat   = ctrl.write_req & local_ready;
  assign rd_accept = ctrl.read_req & local_ready;
  assign burst_adv = burstbegin & local_ready & (ctrl.write_req | ctrl.read_req);

  // bit 0 sequential, bit 2 data mask, bit 7 complete
  assign test_status = {test_complete, 4'b0000, ctrl.dm_mode, 1'b0, seq_mode};

  // ----------------------------------------
  // outstanding read beats
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      reads_pending <= '0;
    end
    else
    begin
      case ({rd_accept, local_rdata_valid})
        2'b10:   reads_pending <= reads_pending + 8'(ddr_drv_pkg::burst_len);
        2'b11:   reads_pending <= reads_pending + 8'(ddr_drv_pkg::burst_len) - 8'd1;
        2'b01:   reads_pending <= reads_pending - 8'd1;
        default: reads_pending <= reads_pending;
      endcase
    end
  end

  // ----------------------------------------
  // pass FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= ddr_drv_pkg::start;
      ctrl          <= '0;
      burstbegin    <= 1'b0;
      beat_cnt      <= '0;
      seq_pending   <= 1'b0;
      dm_pending    <= 1'b0;
      seq_mode      <= 1'b0;
      last_burst    <= 1'b0;
      test_complete <= 1'b0;
    end
    else
    begin
      // one-cycle strobes
      ctrl.reset_address <= 1'b0;
      ctrl.reset_be      <= 1'b0;
      ctrl.dgen_load     <= 1'b0;
      ctrl.capture_seed  <= 1'b0;

      case (state)
        ddr_drv_pkg::start:
        begin
          seq_pending <= 1'b1;
          dm_pending  <= 1'b1;
          state       <= ddr_drv_pkg::pick_pass;
        end

        ddr_drv_pkg::pick_pass:
        begin
          if (seq_pending || dm_pending)
          begin
            ctrl.write_req    <= 1'b1;
            ctrl.capture_seed <= 1'b1;
            burstbegin        <= 1'b1;
            last_burst        <= 1'b0;
            state             <= ddr_drv_pkg::write_first;
            if (seq_pending)
              seq_mode <= 1'b1;
            else
            begin
              // data mask pass opens with a zero fill
              ctrl.dm_mode   <= 1'b1;
              ctrl.zero_fill <= 1'b1;
            end
          end
          else
          begin
            test_complete <= 1'b1;
            state         <= ddr_drv_pkg::done;
          end
        end

        ddr_drv_pkg::write_first:
        begin
          if (wr_beat)
          begin
            burstbegin <= 1'b0;
            beat_cnt   <= 3'd1;
            last_burst <= last_addr;
            state      <= ddr_drv_pkg::write_beat;
          end
        end

        ddr_drv_pkg::write_beat:
        begin
          if (wr_beat)
          begin
            if (beat_cnt == ddr_drv_pkg::beat_cnt_t'(ddr_drv_pkg::burst_len - 1))
            begin
              beat_cnt <= '0;
              if (last_burst)
              begin
                ctrl.write_req     <= 1'b0;
                ctrl.reset_address <= 1'b1;
                ctrl.dgen_load     <= 1'b1;
                ctrl.reset_be      <= ctrl.dm_mode;
                state              <= ddr_drv_pkg::write_last;
              end
              else
              begin
                burstbegin <= 1'b1;
                state      <= ddr_drv_pkg::write_first;
              end
            end
            else
              beat_cnt <= beat_cnt + 3'd1;
          end
        end

        ddr_drv_pkg::write_last:
        begin
          burstbegin <= 1'b1;
          last_burst <= 1'b0;
          if (ctrl.zero_fill)
          begin
            // masked writes over the same range
            ctrl.zero_fill <= 1'b0;
            ctrl.write_req <= 1'b1;
            state          <= ddr_drv_pkg::write_first;
          end
          else
          begin
            ctrl.read_req <= 1'b1;
            state         <= ddr_drv_pkg::read_issue;
          end
        end

        ddr_drv_pkg::read_issue:
        begin
          if (rd_accept && last_addr)
          begin
            ctrl.read_req <= 1'b0;
            burstbegin    <= 1'b0;
            state         <= ddr_drv_pkg::read_drain;
          end
        end

        ddr_drv_pkg::read_drain:
        begin
          // hold until every read beat is back
          if (reads_pending == '0)
          begin
            ctrl.reset_address <= 1'b1;
            if (seq_mode)
            begin
              seq_mode    <= 1'b0;
              seq_pending <= 1'b0;
            end
            else
            begin
              ctrl.dm_mode <= 1'b0;
              dm_pending   <= 1'b0;
            end
            state <= ddr_drv_pkg::pick_pass;
          end
        end

        default:
        begin
          test_complete <= 1'b1;
          state         <= ddr_drv_pkg::done;
        end
      endcase
    end
  end

endmodule

// ==== source/ddr_drv_pkg.sv ====
// package: widths, address limits, LFSR seeds, vector types, control structs, sequencer states
package ddr_drv_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int data_width = 32;
  localparam int lane_count = 4;

  typedef logic [0:0]                       cs_t;
  typedef logic [1:0]                       bank_t;
  typedef logic [12:0]                      row_t;
  typedef logic [8:0]                       col_t;
  typedef logic [data_width-1:0]            data_t;
  typedef logic [data_width/lane_count-1:0] lane_t;
  typedef logic [lane_count-1:0]            be_t;
  typedef logic [2:0]                       size_t;
  typedef logic [2:0]                       beat_cnt_t;
  typedef logic [7:0]                       status_t;

  // ----------------------------------------
  // burst and address range
  // ----------------------------------------
  localparam size_t burst_len = 3'd2;
  localparam col_t  col_step  = 9'd4;
  localparam col_t  max_col   = 9'd16;
  localparam row_t  max_row   = 13'd3;
  localparam bank_t max_bank  = 2'd3;
  localparam cs_t   max_cs    = 1'b0;

  // lane 0 seed in the low byte
  localparam lane_t [lane_count-1:0] lane_seed = {8'd31, 8'd21, 8'd11, 8'd1};

  typedef struct packed {
    cs_t   cs;
    bank_t bank;
    row_t  row;
    col_t  col;
  } mem_addr_t;

  // sequencer to address and pattern generators
  typedef struct packed {
    logic write_req;
    logic read_req;
    logic reset_address;
    logic reset_be;
    logic zero_fill;
    logic dgen_load;
    logic capture_seed;
    logic dm_mode;
  } seq_ctrl_t;

  typedef enum logic [2:0] {
    start,
    pick_pass,
    write_first,
    write_beat,
    write_last,
    read_issue,
    read_drain,
    done
  } seq_state_t;

endpackage
